//--- logic/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Word addressed, one word per line
`define CACHE_ADDR_BITS  16
`define CACHE_WORD_BITS  32
`define CACHE_INDEX_BITS 3
`define CACHE_TAG_BITS   (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS)

// Tree pseudo-LRU is built for exactly four ways
`define CACHE_WAYS 4

`endif

//--- logic/cache_types_pkg.sv
package cache_types_pkg;

  // Controller states
  typedef enum logic [1:0] {
    idle,
    miss,
    hit_resp,
    write_back
  } cache_state_t;

  // Write source for the data array
  typedef enum logic [1:0] {
    no_write,
    cpu_write_cache,
    mem_write_cache
  } data_src_t;

  // Memory address source
  typedef enum logic {
    cache_read_mem,
    cache_write_mem
  } pmem_addr_sel_t;

  typedef enum logic [1:0] {
    owner_none,
    owner_c0,
    owner_c1
  } arb_owner_t;

endpackage : cache_types_pkg

//--- logic/cache_control.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_control
  import cache_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mem_read,
  input  logic                   mem_write,
  output logic                   mem_resp,
  input  logic                   pmem_resp,
  output logic                   pmem_read,
  output logic                   pmem_write,
  input  logic                   hit,
  input  logic [`CACHE_WAYS-1:0] way_hit,
  input  logic [`CACHE_WAYS-1:0] valid,
  input  logic [2:0]             lru,
  input  logic                   victim_dirty,
  output logic [`CACHE_WAYS-1:0] tag_load,
  output logic [`CACHE_WAYS-1:0] valid_load,
  output logic                   valid_in,
  output logic [`CACHE_WAYS-1:0] dirty_load,
  output logic                   dirty_in,
  output logic [`CACHE_WAYS-1:0] data_write_way,
  output data_src_t              data_src,
  output logic                   lru_load,
  output logic [2:0]             lru_in,
  output logic [1:0]             rdata_way_sel,
  output pmem_addr_sel_t         pmem_addr_sel
);

  cache_state_t           state;
  cache_state_t           state_next;
  logic [1:0]             victim;
  logic [`CACHE_WAYS-1:0] victim_oh;
  logic [1:0]             hit_way;

  // Lowest invalid way first, then the tree victim
  always_comb
  begin
    if (!valid[0])
      victim = 2'd0;
    else if (!valid[1])
      victim = 2'd1;
    else if (!valid[2])
      victim = 2'd2;
    else if (!valid[3])
      victim = 2'd3;
    else if (!lru[2])
      victim = lru[0] ? 2'd2 : 2'd3;
    else
      victim = lru[1] ? 2'd0 : 2'd1;
  end

  assign victim_oh = {{(`CACHE_WAYS-1){1'b0}}, 1'b1} << victim;

  always_comb
  begin
    hit_way = 2'd0;
    for (int w = 0; w < `CACHE_WAYS; w++)
      if (way_hit[w])
        hit_way = 2'(w);
  end

  always_comb
  begin
    mem_resp       = 1'b0;
    pmem_read      = 1'b0;
    pmem_write     = 1'b0;
    tag_load       = '0;
    valid_load     = '0;
    valid_in       = 1'b0;
    dirty_load     = '0;
    dirty_in       = 1'b0;
    data_write_way = '0;
    data_src       = no_write;
    lru_load       = 1'b0;
    lru_in         = lru;
    rdata_way_sel  = 2'd0;
    pmem_addr_sel  = cache_read_mem;

    case (state)
      miss:
      begin
        pmem_read = !victim_dirty;
        if (!victim_dirty && pmem_resp)
        begin
          // Fill lands clean in the victim way
          tag_load       = victim_oh;
          valid_load     = victim_oh;
          valid_in       = 1'b1;
          dirty_load     = victim_oh;
          data_write_way = victim_oh;
          data_src       = mem_write_cache;
        end
      end

      hit_resp:
      begin
        mem_resp      = 1'b1;
        rdata_way_sel = hit_way;
        lru_load      = hit;
        if (hit_way[1])
          lru_in = {1'b1, lru[1], hit_way[0]};
        else
          lru_in = {1'b0, hit_way[0], lru[0]};
        if (mem_write)
        begin
          data_write_way = way_hit;
          data_src       = cpu_write_cache;
          dirty_load     = way_hit;
          dirty_in       = 1'b1;
        end
      end

      write_back:
      begin
        pmem_write    = 1'b1;
        pmem_addr_sel = cache_write_mem;
        rdata_way_sel = victim;
        // Victim becomes clean and invalid once memory has the word
        if (pmem_resp)
        begin
          valid_load = victim_oh;
          dirty_load = victim_oh;
        end
      end

      default:
      begin
      end
    endcase
  end

  always_comb
  begin
    state_next = state;
    case (state)
      idle:
        if (mem_read || mem_write)
          state_next = hit ? hit_resp : miss;
      miss:
        if (victim_dirty)
          state_next = write_back;
        else if (pmem_resp)
          state_next = hit_resp;
      hit_resp:
        state_next = idle;
      write_back:
        if (pmem_resp)
          state_next = miss;
      default:
        state_next = idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= state_next;
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(data_write_way));

  assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write));

endmodule : cache_control

//--- logic/cache_datapath.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_datapath
  import cache_types_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`CACHE_ADDR_BITS-1:0] mem_addr,
  input  logic [`CACHE_WORD_BITS-1:0] mem_wdata,
  output logic [`CACHE_WORD_BITS-1:0] mem_rdata,
  input  logic [`CACHE_WAYS-1:0]      tag_load,
  input  logic [`CACHE_WAYS-1:0]      valid_load,
  input  logic                        valid_in,
  input  logic [`CACHE_WAYS-1:0]      dirty_load,
  input  logic                        dirty_in,
  input  logic [`CACHE_WAYS-1:0]      data_write_way,
  input  data_src_t                   data_src,
  input  logic                        lru_load,
  input  logic [2:0]                  lru_in,
  input  logic [1:0]                  rdata_way_sel,
  input  pmem_addr_sel_t              pmem_addr_sel,
  output logic                        hit,
  output logic [`CACHE_WAYS-1:0]      way_hit,
  output logic [`CACHE_WAYS-1:0]      valid,
  output logic [2:0]                  lru,
  output logic                        victim_dirty,
  output logic [`CACHE_ADDR_BITS-1:0] c_pmem_addr,
  output logic [`CACHE_WORD_BITS-1:0] c_pmem_wdata,
  input  logic [`CACHE_WORD_BITS-1:0] c_pmem_rdata
);

  localparam int SETS = 1 << `CACHE_INDEX_BITS;

  logic [`CACHE_TAG_BITS-1:0]   tag_mem  [`CACHE_WAYS][SETS];
  logic [`CACHE_WORD_BITS-1:0]  data_mem [`CACHE_WAYS][SETS];
  logic [SETS-1:0]              valid_q  [`CACHE_WAYS];
  logic [SETS-1:0]              dirty_q  [`CACHE_WAYS];
  logic [2:0]                   lru_q    [SETS];

  logic [`CACHE_INDEX_BITS-1:0] idx;
  logic [`CACHE_TAG_BITS-1:0]   tag;
  logic [1:0]                   lru_way;
  logic [`CACHE_WORD_BITS-1:0]  wr_data;
  logic [`CACHE_WORD_BITS-1:0]  sel_data;

  assign idx = mem_addr[`CACHE_INDEX_BITS-1:0];
  assign tag = mem_addr[`CACHE_ADDR_BITS-1:`CACHE_INDEX_BITS];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int w = 0; w < `CACHE_WAYS; w++)
      begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      for (int s = 0; s < SETS; s++)
        lru_q[s] <= '0;
    end
    else
    begin
      for (int w = 0; w < `CACHE_WAYS; w++)
      begin
        if (valid_load[w])
          valid_q[w][idx] <= valid_in;
        if (dirty_load[w])
          dirty_q[w][idx] <= dirty_in;
      end
      if (lru_load)
        lru_q[idx] <= lru_in;
    end
  end

  assign wr_data = (data_src == mem_write_cache) ? c_pmem_rdata : mem_wdata;

  always_ff @(posedge clk)
  begin
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      if (tag_load[w])
        tag_mem[w][idx] <= tag;
      if (data_write_way[w] && data_src != no_write)
        data_mem[w][idx] <= wr_data;
    end
  end

  // Tag compare on the addressed set
  always_comb
  begin
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      valid[w]   = valid_q[w][idx];
      way_hit[w] = valid_q[w][idx] && (tag_mem[w][idx] == tag);
    end
  end

  assign hit = |way_hit;
  assign lru = lru_q[idx];

  // Tree victim, only meaningful once the set is full
  assign lru_way      = !lru[2] ? (lru[0] ? 2'd2 : 2'd3) : (lru[1] ? 2'd0 : 2'd1);
  assign victim_dirty = (&valid) && dirty_q[lru_way][idx];

  assign sel_data     = data_mem[rdata_way_sel][idx];
  assign mem_rdata    = sel_data;
  assign c_pmem_wdata = sel_data;

  assign c_pmem_addr = (pmem_addr_sel == cache_write_mem) ?
                       {tag_mem[rdata_way_sel][idx], idx} : mem_addr;

endmodule : cache_datapath

//--- logic/pmem_arbiter.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module pmem_arbiter
  import cache_types_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        c0_pmem_read,
  input  logic                        c0_pmem_write,
  input  logic [`CACHE_ADDR_BITS-1:0] c0_pmem_addr,
  input  logic [`CACHE_WORD_BITS-1:0] c0_pmem_wdata,
  output logic                        c0_pmem_resp,
  output logic [`CACHE_WORD_BITS-1:0] c0_pmem_rdata,
  input  logic                        c1_pmem_read,
  input  logic                        c1_pmem_write,
  input  logic [`CACHE_ADDR_BITS-1:0] c1_pmem_addr,
  input  logic [`CACHE_WORD_BITS-1:0] c1_pmem_wdata,
  output logic                        c1_pmem_resp,
  output logic [`CACHE_WORD_BITS-1:0] c1_pmem_rdata,
  output logic                        pmem_read,
  output logic                        pmem_write,
  output logic [`CACHE_ADDR_BITS-1:0] pmem_addr,
  output logic [`CACHE_WORD_BITS-1:0] pmem_wdata,
  input  logic                        pmem_resp,
  input  logic [`CACHE_WORD_BITS-1:0] pmem_rdata
);

  arb_owner_t owner_q;
  arb_owner_t owner;
  logic       last_c1;
  logic       c0_req;
  logic       c1_req;

  assign c0_req = c0_pmem_read || c0_pmem_write;
  assign c1_req = c1_pmem_read || c1_pmem_write;

  // Grant in the same cycle when free, ties go away from the last owner
  always_comb
  begin
    owner = owner_q;
    if (owner_q == owner_none)
    begin
      if (c0_req && c1_req)
        owner = last_c1 ? owner_c0 : owner_c1;
      else if (c0_req)
        owner = owner_c0;
      else if (c1_req)
        owner = owner_c1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner_q <= owner_none;
      last_c1 <= 1'b0;
    end
    else
    begin
      owner_q <= pmem_resp ? owner_none : owner;
      if (owner != owner_none)
        last_c1 <= (owner == owner_c1);
    end
  end

  always_comb
  begin
    pmem_read  = 1'b0;
    pmem_write = 1'b0;
    pmem_addr  = c0_pmem_addr;
    pmem_wdata = c0_pmem_wdata;
    case (owner)
      owner_c0:
      begin
        pmem_read  = c0_pmem_read;
        pmem_write = c0_pmem_write;
      end
      owner_c1:
      begin
        pmem_read  = c1_pmem_read;
        pmem_write = c1_pmem_write;
        pmem_addr  = c1_pmem_addr;
        pmem_wdata = c1_pmem_wdata;
      end
      default:
      begin
      end
    endcase
  end

  assign c0_pmem_resp  = pmem_resp && (owner == owner_c0);
  assign c1_pmem_resp  = pmem_resp && (owner == owner_c1);
  assign c0_pmem_rdata = pmem_rdata;
  assign c1_pmem_rdata = pmem_rdata;

  assert property (@(posedge clk) disable iff (rst)
    (owner == owner_c0) && c0_req && !pmem_resp |=> owner == owner_c0);

  assert property (@(posedge clk) disable iff (rst)
    (owner == owner_c1) && c1_req && !pmem_resp |=> owner == owner_c1);

endmodule : pmem_arbiter

//--- logic/split_cache_top.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module split_cache_top
  import cache_types_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        mem_read_0,
  input  logic                        mem_write_0,
  input  logic [`CACHE_ADDR_BITS-1:0] mem_addr_0,
  input  logic [`CACHE_WORD_BITS-1:0] mem_wdata_0,
  output logic                        mem_resp_0,
  output logic [`CACHE_WORD_BITS-1:0] mem_rdata_0,
  input  logic                        mem_read_1,
  input  logic                        mem_write_1,
  input  logic [`CACHE_ADDR_BITS-1:0] mem_addr_1,
  input  logic [`CACHE_WORD_BITS-1:0] mem_wdata_1,
  output logic                        mem_resp_1,
  output logic [`CACHE_WORD_BITS-1:0] mem_rdata_1,
  output logic                        pmem_read,
  output logic                        pmem_write,
  output logic [`CACHE_ADDR_BITS-1:0] pmem_addr,
  output logic [`CACHE_WORD_BITS-1:0] pmem_wdata,
  input  logic                        pmem_resp,
  input  logic [`CACHE_WORD_BITS-1:0] pmem_rdata
);

  logic [1:0]                  req_read;
  logic [1:0]                  req_write;
  logic [1:0]                  req_resp;
  logic [`CACHE_ADDR_BITS-1:0] req_addr     [2];
  logic [`CACHE_WORD_BITS-1:0] req_wdata    [2];
  logic [`CACHE_WORD_BITS-1:0] req_rdata    [2];
  logic [1:0]                  c_pmem_read;
  logic [1:0]                  c_pmem_write;
  logic [1:0]                  c_pmem_resp;
  logic [`CACHE_ADDR_BITS-1:0] c_pmem_addr  [2];
  logic [`CACHE_WORD_BITS-1:0] c_pmem_wdata [2];
  logic [`CACHE_WORD_BITS-1:0] c_pmem_rdata [2];

  assign req_read     = {mem_read_1, mem_read_0};
  assign req_write    = {mem_write_1, mem_write_0};
  assign req_addr[0]  = mem_addr_0;
  assign req_addr[1]  = mem_addr_1;
  assign req_wdata[0] = mem_wdata_0;
  assign req_wdata[1] = mem_wdata_1;
  assign mem_resp_0   = req_resp[0];
  assign mem_resp_1   = req_resp[1];
  assign mem_rdata_0  = req_rdata[0];
  assign mem_rdata_1  = req_rdata[1];

  // One controller and datapath per requester port
  for (genvar c = 0; c < 2; c++)
  begin : g_cache
    logic                   hit;
    logic                   victim_dirty;
    logic                   valid_in;
    logic                   dirty_in;
    logic                   lru_load;
    logic [`CACHE_WAYS-1:0] way_hit;
    logic [`CACHE_WAYS-1:0] valid;
    logic [`CACHE_WAYS-1:0] tag_load;
    logic [`CACHE_WAYS-1:0] valid_load;
    logic [`CACHE_WAYS-1:0] dirty_load;
    logic [`CACHE_WAYS-1:0] data_write_way;
    logic [2:0]             lru;
    logic [2:0]             lru_in;
    logic [1:0]             rdata_way_sel;
    data_src_t              data_src;
    pmem_addr_sel_t         pmem_addr_sel;

    cache_control i_cache_control (
      .clk, .rst,
      .mem_read   (req_read[c]),     .mem_write  (req_write[c]),
      .mem_resp   (req_resp[c]),     .pmem_resp  (c_pmem_resp[c]),
      .pmem_read  (c_pmem_read[c]),  .pmem_write (c_pmem_write[c]),
      .hit, .way_hit, .valid, .lru, .victim_dirty,
      .tag_load, .valid_load, .valid_in, .dirty_load, .dirty_in,
      .data_write_way, .data_src, .lru_load, .lru_in,
      .rdata_way_sel, .pmem_addr_sel
    );

    cache_datapath i_cache_datapath (
      .clk, .rst,
      .mem_addr     (req_addr[c]),     .mem_wdata    (req_wdata[c]),
      .mem_rdata    (req_rdata[c]),    .c_pmem_rdata (c_pmem_rdata[c]),
      .c_pmem_addr  (c_pmem_addr[c]),  .c_pmem_wdata (c_pmem_wdata[c]),
      .tag_load, .valid_load, .valid_in, .dirty_load, .dirty_in,
      .data_write_way, .data_src, .lru_load, .lru_in,
      .rdata_way_sel, .pmem_addr_sel,
      .hit, .way_hit, .valid, .lru, .victim_dirty
    );
  end

  pmem_arbiter i_pmem_arbiter (
    .clk, .rst,
    .c0_pmem_read  (c_pmem_read[0]),  .c0_pmem_write (c_pmem_write[0]),
    .c0_pmem_addr  (c_pmem_addr[0]),  .c0_pmem_wdata (c_pmem_wdata[0]),
    .c0_pmem_resp  (c_pmem_resp[0]),  .c0_pmem_rdata (c_pmem_rdata[0]),
    .c1_pmem_read  (c_pmem_read[1]),  .c1_pmem_write (c_pmem_write[1]),
    .c1_pmem_addr  (c_pmem_addr[1]),  .c1_pmem_wdata (c_pmem_wdata[1]),
    .c1_pmem_resp  (c_pmem_resp[1]),  .c1_pmem_rdata (c_pmem_rdata[1]),
    .pmem_read, .pmem_write, .pmem_addr, .pmem_wdata, .pmem_resp, .pmem_rdata
  );

endmodule : split_cache_top

//--- tests/pmem_model.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module pmem_model (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        pmem_read,
  input  logic                        pmem_write,
  input  logic [`CACHE_ADDR_BITS-1:0] pmem_addr,
  input  logic [`CACHE_WORD_BITS-1:0] pmem_wdata,
  output logic                        pmem_resp,
  output logic [`CACHE_WORD_BITS-1:0] pmem_rdata
);

  logic [`CACHE_WORD_BITS-1:0] mem [1 << `CACHE_ADDR_BITS];
  integer                      seed = 32'h192d78ee;
  logic                        busy = 1'b0;
  int                          delay = 0;
  logic                        resp_q = 1'b0;
  logic [`CACHE_WORD_BITS-1:0] rdata_q = '0;

  assign pmem_resp  = resp_q;
  assign pmem_rdata = rdata_q;

  // Every word starts as its own address folded with a fixed pattern
  initial
  begin
    for (int a = 0; a < (1 << `CACHE_ADDR_BITS); a++)
      mem[a] = a ^ 32'h5a5a0000;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      busy   <= 1'b0;
      delay  <= 0;
      resp_q <= 1'b0;
    end
    else if (resp_q)
    begin
      // Strobe is still up in the response cycle and is not a new request
      resp_q <= 1'b0;
      busy   <= 1'b0;
    end
    else if (!busy)
    begin
      if (pmem_read || pmem_write)
      begin
        busy  <= 1'b1;
        delay <= 1 + ($unsigned($random(seed)) % 5);
      end
    end
    else if (delay > 1)
      delay <= delay - 1;
    else
    begin
      resp_q <= 1'b1;
      if (pmem_write)
      begin
        mem[pmem_addr] = pmem_wdata;
        $display("pmem write at %0t: addr %h data %h", $time, pmem_addr, pmem_wdata);
      end
      else
        rdata_q <= mem[pmem_addr];
    end
  end

endmodule : pmem_model

//--- tests/split_cache_tb.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module split_cache_tb;

  localparam int ADDR_W       = `CACHE_ADDR_BITS;
  localparam int WORD_W       = `CACHE_WORD_BITS;
  localparam int TAG_W        = `CACHE_TAG_BITS;
  localparam int SETS         = 1 << `CACHE_INDEX_BITS;
  localparam int RESP_TIMEOUT = 400;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              mem_read_0 = 1'b0;
  logic              mem_write_0 = 1'b0;
  logic [ADDR_W-1:0] mem_addr_0 = '0;
  logic [WORD_W-1:0] mem_wdata_0 = '0;
  logic              mem_resp_0;
  logic [WORD_W-1:0] mem_rdata_0;
  logic              mem_read_1 = 1'b0;
  logic              mem_write_1 = 1'b0;
  logic [ADDR_W-1:0] mem_addr_1 = '0;
  logic [WORD_W-1:0] mem_wdata_1 = '0;
  logic              mem_resp_1;
  logic [WORD_W-1:0] mem_rdata_1;
  logic              pmem_read;
  logic              pmem_write;
  logic [ADDR_W-1:0] pmem_addr;
  logic [WORD_W-1:0] pmem_wdata;
  logic              pmem_resp;
  logic [WORD_W-1:0] pmem_rdata;

  // Reference cache state per port
  logic [TAG_W-1:0]  ref_tag   [2][SETS][4];
  logic              ref_valid [2][SETS][4];
  logic              ref_dirty [2][SETS][4];
  logic [2:0]        ref_lru   [2][SETS];
  logic [WORD_W-1:0] shadow    [int];
  logic [ADDR_W-1:0] last_evict_addr;

  logic [WORD_W-1:0] exp_rdata   [2][$];
  logic [ADDR_W-1:0] exp_wb_addr [2][$];
  logic [WORD_W-1:0] exp_wb_data [2][$];

  int   errors = 0;
  int   tests_run = 0;
  int   tests_failed = 0;
  int   wb_count = 0;
  int   pmem_txn_count = 0;
  logic txn_open = 1'b0;
  logic txn_half = 1'b0;

  always #10 clk = ~clk;

  split_cache_top i_split_cache_top (
    .clk, .rst,
    .mem_read_0, .mem_write_0, .mem_addr_0, .mem_wdata_0, .mem_resp_0, .mem_rdata_0,
    .mem_read_1, .mem_write_1, .mem_addr_1, .mem_wdata_1, .mem_resp_1, .mem_rdata_1,
    .pmem_read, .pmem_write, .pmem_addr, .pmem_wdata, .pmem_resp, .pmem_rdata
  );

  pmem_model i_pmem_model (
    .clk, .rst,
    .pmem_read, .pmem_write, .pmem_addr, .pmem_wdata, .pmem_resp, .pmem_rdata
  );

  function automatic logic [WORD_W-1:0] mem_rule(logic [ADDR_W-1:0] addr);
    logic [WORD_W-1:0] word;
    word = '0;
    word[ADDR_W-1:0] = addr;
    return word ^ 32'h5a5a0000;
  endfunction

  function automatic int shadow_key(int port, logic [ADDR_W-1:0] addr);
    return port * (1 << ADDR_W) + int'(addr);
  endfunction

  function automatic logic [WORD_W-1:0] shadow_read(int port, logic [ADDR_W-1:0] addr);
    int k;
    k = shadow_key(port, addr);
    if (shadow.exists(k))
      return shadow[k];
    return mem_rule(addr);
  endfunction

  function automatic int pick_victim(int port, int idx);
    logic [2:0] l;
    l = ref_lru[port][idx];
    for (int w = 0; w < 4; w++)
      if (!ref_valid[port][idx][w])
        return w;
    if (!l[2])
      return l[0] ? 2 : 3;
    return l[1] ? 0 : 1;
  endfunction

  // Expected read data; queues the write-back a dirty eviction must produce
  function automatic logic [WORD_W-1:0] ref_access(int port, bit is_write,
                                                    logic [ADDR_W-1:0] addr,
                                                    logic [WORD_W-1:0] wdata);
    int               idx;
    int               way;
    logic [TAG_W-1:0] tag;
    logic [ADDR_W-1:0] wb_addr;
    idx = int'(addr[2:0]);
    tag = addr[ADDR_W-1:3];
    way = -1;
    for (int w = 0; w < 4; w++)
      if (ref_valid[port][idx][w] && ref_tag[port][idx][w] == tag)
        way = w;
    if (way < 0)
    begin
      way = pick_victim(port, idx);
      if (ref_valid[port][idx][way])
      begin
        wb_addr = {ref_tag[port][idx][way], addr[2:0]};
        last_evict_addr = wb_addr;
        if (ref_dirty[port][idx][way])
        begin
          exp_wb_addr[port].push_back(wb_addr);
          exp_wb_data[port].push_back(shadow_read(port, wb_addr));
        end
      end
      ref_tag[port][idx][way]   = tag;
      ref_valid[port][idx][way] = 1'b1;
      ref_dirty[port][idx][way] = 1'b0;
    end
    if (way < 2)
      ref_lru[port][idx] = {1'b0, way[0], ref_lru[port][idx][0]};
    else
      ref_lru[port][idx] = {1'b1, ref_lru[port][idx][1], way[0]};
    if (is_write)
    begin
      ref_dirty[port][idx][way] = 1'b1;
      shadow[shadow_key(port, addr)] = wdata;
    end
    return shadow_read(port, addr);
  endfunction

  task automatic clear_reference();
    for (int p = 0; p < 2; p++)
      for (int s = 0; s < SETS; s++)
      begin
        ref_lru[p][s] = '0;
        for (int w = 0; w < 4; w++)
        begin
          ref_valid[p][s][w] = 1'b0;
          ref_dirty[p][s][w] = 1'b0;
        end
      end
    shadow.delete();
  endtask

  task automatic drive_req(input int port, input logic rd, input logic wr,
                           input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata);
    if (port == 0)
    begin
      mem_read_0  <= rd;
      mem_write_0 <= wr;
      mem_addr_0  <= addr;
      mem_wdata_0 <= wdata;
    end
    else
    begin
      mem_read_1  <= rd;
      mem_write_1 <= wr;
      mem_addr_1  <= addr;
      mem_wdata_1 <= wdata;
    end
  endtask

  // Hold the request until mem_resp, cycles counts from the request cycle
  task automatic do_access(input int port, input bit is_write,
                           input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata,
                           output int cycles);
    logic [WORD_W-1:0] expected;
    logic              got;
    expected = ref_access(port, is_write, addr, wdata);
    if (!is_write)
      exp_rdata[port].push_back(expected);
    @(posedge clk);
    drive_req(port, !is_write, is_write, addr, wdata);
    cycles = 0;
    got = 1'b0;
    while (!got && cycles < RESP_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      got = (port == 0) ? mem_resp_0 : mem_resp_1;
    end
    if (!got)
    begin
      $display("Timeout: port %0d got no response for address %h within %0d cycles",
               port, addr, RESP_TIMEOUT);
      errors++;
    end
    @(posedge clk);
    drive_req(port, 1'b0, 1'b0, addr, wdata);
  endtask

  task automatic check_read(input int port, input logic [WORD_W-1:0] got);
    logic [WORD_W-1:0] expected;
    assert (exp_rdata[port].size() != 0) else
    begin
      $display("Port %0d answered a read that was never issued", port);
      errors++;
    end
    if (exp_rdata[port].size() != 0)
    begin
      expected = exp_rdata[port].pop_front();
      assert (got == expected) else
      begin
        $display("CHECK FAILED at %0t: port %0d read data %h, expected %h",
                 $time, port, got, expected);
        errors++;
      end
    end
  endtask

  task automatic check_write_back(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
    int port;
    port = addr[ADDR_W-1] ? 1 : 0;
    wb_count++;
    assert (exp_wb_addr[port].size() != 0) else
    begin
      $display("Cache %0d wrote back address %h although no eviction was dirty", port, addr);
      errors++;
    end
    if (exp_wb_addr[port].size() != 0)
    begin
      assert (addr == exp_wb_addr[port][0] && data == exp_wb_data[port][0]) else
      begin
        $display("CHECK FAILED at %0t: write-back %h <= %h, expected %h <= %h", $time,
                 addr, data, exp_wb_addr[port][0], exp_wb_data[port][0]);
        errors++;
      end
      void'(exp_wb_addr[port].pop_front());
      void'(exp_wb_data[port].pop_front());
    end
  endtask

  // Memory port must stay with one cache from strobe to pmem_resp
  task automatic check_owner();
    assert (!(pmem_read && pmem_write)) else
    begin
      $display("CHECK FAILED at %0t: pmem_read and pmem_write both high", $time);
      errors++;
    end
    if (pmem_read || pmem_write)
    begin
      if (txn_open)
      begin
        assert (pmem_addr[ADDR_W-1] == txn_half) else
        begin
          $display("CHECK FAILED at %0t: memory port changed owner mid transfer", $time);
          errors++;
        end
      end
      else
      begin
        txn_open = 1'b1;
        txn_half = pmem_addr[ADDR_W-1];
      end
    end
    if (pmem_resp)
      txn_open = 1'b0;
  endtask

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (mem_resp_0 && mem_read_0)
        check_read(0, mem_rdata_0);
      if (mem_resp_1 && mem_read_1)
        check_read(1, mem_rdata_1);
      if (pmem_resp && pmem_write)
        check_write_back(pmem_addr, pmem_wdata);
      if (pmem_resp)
        pmem_txn_count++;
      check_owner();
    end
  end

  task automatic check_cycles(input int cycles, input int expected, input string what);
    assert (cycles == expected) else
    begin
      $display("CHECK FAILED at %0t: %s took %0d cycles, expected %0d",
               $time, what, cycles, expected);
      errors++;
    end
  endtask

  task automatic check_drained();
    for (int p = 0; p < 2; p++)
    begin
      assert (exp_rdata[p].size() == 0 && exp_wb_addr[p].size() == 0) else
      begin
        $display("Port %0d still waits for %0d reads and %0d write-backs", p,
                 exp_rdata[p].size(), exp_wb_addr[p].size());
        errors++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d error(s)", tests_run, name, errors - errors_before);
    end
  endtask

  initial
  begin
    int                errors_before;
    int                cycles;
    int                cycles_1;
    int                count_before;
    logic [ADDR_W-1:0] evicted;

    clear_reference();
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    errors_before = errors;
    for (int i = 0; i < 20; i++)
    begin
      @(negedge clk);
      assert (!mem_resp_0 && !mem_resp_1 && !pmem_read && !pmem_write) else
      begin
        $display("CHECK FAILED at %0t: output active with no request applied", $time);
        errors++;
      end
    end
    finish_test("quiet after reset", errors_before);

    errors_before = errors;
    count_before = pmem_txn_count;
    do_access(0, 1'b0, 16'h0123, '0, cycles);
    assert (pmem_txn_count == count_before + 1) else
    begin
      $display("CHECK FAILED at %0t: read miss made %0d memory transfers, expected 1",
               $time, pmem_txn_count - count_before);
      errors++;
    end
    do_access(0, 1'b0, 16'h0123, '0, cycles);
    check_cycles(cycles, 2, "read hit");
    finish_test("read miss then hit", errors_before);

    errors_before = errors;
    count_before = pmem_txn_count;
    do_access(0, 1'b1, 16'h0123, 32'hcafe0123, cycles);
    check_cycles(cycles, 2, "write hit");
    do_access(0, 1'b0, 16'h0123, '0, cycles);
    check_cycles(cycles, 2, "read after write hit");
    assert (pmem_txn_count == count_before) else
    begin
      $display("CHECK FAILED at %0t: hits caused memory traffic", $time);
      errors++;
    end
    finish_test("write hit then read", errors_before);

    // Fill set 5, touch C A D B, then a fifth tag forces an eviction
    errors_before = errors;
    do_access(0, 1'b1, 16'h0085, 32'hd0000085, cycles);
    do_access(0, 1'b1, 16'h008d, 32'hd000008d, cycles);
    do_access(0, 1'b1, 16'h0095, 32'hd0000095, cycles);
    do_access(0, 1'b1, 16'h009d, 32'hd000009d, cycles);
    do_access(0, 1'b0, 16'h0095, '0, cycles);
    do_access(0, 1'b0, 16'h0085, '0, cycles);
    do_access(0, 1'b0, 16'h009d, '0, cycles);
    do_access(0, 1'b0, 16'h008d, '0, cycles);
    count_before = wb_count;
    do_access(0, 1'b1, 16'h00a5, 32'hd00000a5, cycles);
    evicted = last_evict_addr;
    assert (wb_count == count_before + 1) else
    begin
      $display("CHECK FAILED at %0t: eviction made %0d write-backs, expected 1",
               $time, wb_count - count_before);
      errors++;
    end
    do_access(0, 1'b0, evicted, '0, cycles);
    finish_test("tree LRU eviction", errors_before);

    errors_before = errors;
    fork
      do_access(0, 1'b0, 16'h0042, '0, cycles);
      do_access(1, 1'b0, 16'h8042, '0, cycles_1);
    join
    fork
      do_access(0, 1'b1, 16'h004a, 32'h1111004a, cycles);
      do_access(1, 1'b1, 16'h804a, 32'h2222804a, cycles_1);
    join
    fork
      do_access(0, 1'b0, 16'h004a, '0, cycles);
      do_access(1, 1'b0, 16'h8042, '0, cycles_1);
    join
    check_drained();
    finish_test("concurrent misses", errors_before);

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule : split_cache_tb

//--- split_cache_top.f
+incdir+logic
logic/cache_types_pkg.sv
logic/cache_control.sv
logic/cache_datapath.sv
logic/pmem_arbiter.sv
logic/split_cache_top.sv
tests/pmem_model.sv
tests/split_cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the split cache testbench with Verilator, run it, and grade the log

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f split_cache_top.f \
  --top-module split_cache_tb -Mdir obj_dir &&
./obj_dir/Vsplit_cache_tb | tee sim.log

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" ||
{ echo "simulation did not pass"; exit 1; }
